// File: src/fetch_defines.svh
////////////////////////////////////////////////////////////////////////////
// Sizing shared by the fetch and decode front end
// FD_FIFO_DEPTH must be a power of two that matches FD_PTR_W
// FD_CNT_W must be wide enough to hold FD_FIFO_DEPTH itself
////////////////////////////////////////////////////////////////////////////

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Data and address width of the core
`define FD_XLEN 32

// Prefetch FIFO entries
// Also caps the requests in flight on the instruction bus
`define FD_FIFO_DEPTH 4

// FIFO read and write pointer width
`define FD_PTR_W 2

// Counter width for FIFO occupancy and outstanding requests
// One bit more than the pointer so that a full FIFO is visible
`define FD_CNT_W 3

`endif

// File: src/fetch_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Types shared by the fetch and decode front end
// Only RV32 base encodings are known here and compressed forms are absent
////////////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

package fetch_pkg;

  // RV32 major opcodes with the low bits 11 included
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    SYSTEM = 7'b1110011
  } opcode_e;

  // Instruction formats as the decoder reports them
  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J,
    FMT_ILL
  } instr_fmt_e;

  // Register-register layout
  // Also serves S and B, whose immediate sits in funct7 and rd
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  // Immediate layout
  // Bits [31:12] here are also the U and J payload
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_view_t;

  // Two readings of one instruction word
  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
  } instr_u;

  // One fetched word as it travels through the FIFO
  typedef struct packed {
    logic [`FD_XLEN-1:0] pc;
    logic [`FD_XLEN-1:0] instr;
    logic                bus_err;
  } fetch_entry_t;

  // Decoded packet at the front end output
  typedef struct packed {
    logic [`FD_XLEN-1:0] pc;
    logic [`FD_XLEN-1:0] instr;
    instr_fmt_e          fmt;
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`FD_XLEN-1:0] imm;
    logic                illegal;
  } decoded_t;

endpackage

// File: src/prefetcher.sv
////////////////////////////////////////////////////////////////////////////
// Instruction bus master with word-aligned requests and in-order responses
// Requests are gated so that every response finds room in the FIFO
// A jump drops all responses owed to earlier requests
////////////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

module prefetcher (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [`FD_XLEN-1:0]     boot_addr_i,
  input  logic                    jump_valid_i,
  input  logic [`FD_XLEN-1:0]     jump_target_i,
  // Instruction bus
  output logic                    instr_req_o,
  output logic [`FD_XLEN-1:0]     instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  logic [`FD_XLEN-1:0]     instr_rdata_i,
  input  logic                    instr_err_i,
  // FIFO side
  input  logic [`FD_CNT_W-1:0]    fifo_count_i,
  output logic                    push_o,
  output fetch_pkg::fetch_entry_t push_entry_o
);

  logic                 boot_done_q;
  logic [`FD_XLEN-1:0]  pc_q;
  logic                 jmp_pend_q;
  logic [`FD_XLEN-1:0]  jmp_tgt_q;
  logic [`FD_CNT_W-1:0] out_cnt_q;
  logic [`FD_CNT_W-1:0] out_cnt_d;
  logic [`FD_CNT_W-1:0] drop_cnt_q;
  logic [`FD_CNT_W:0]   credit_sum;
  logic                 grant;
  logic                 stall;
  logic                 drop_rsp;
  // Addresses of granted requests, oldest at the read pointer
  logic [`FD_XLEN-1:0]  aq_mem [`FD_FIFO_DEPTH];
  logic [`FD_PTR_W-1:0] aq_wr_ptr_q;
  logic [`FD_PTR_W-1:0] aq_rd_ptr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  // Credit covers words in flight plus words already queued
  assign credit_sum = {1'b0, out_cnt_q} + {1'b0, fifo_count_i};

  // Sum cannot grow while a request waits, so req holds until granted
  assign instr_req_o  = boot_done_q && (credit_sum < `FD_FIFO_DEPTH);
  assign instr_addr_o = pc_q;

  assign grant = instr_req_o & instr_gnt_i;
  assign stall = instr_req_o & ~instr_gnt_i;

  // Fetch pc and redirect
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      boot_done_q <= 1'b0;
      pc_q        <= '0;
      jmp_pend_q  <= 1'b0;
    end else if (!boot_done_q) begin
      // First cycle out of reset samples the boot address
      boot_done_q <= 1'b1;
      pc_q        <= boot_addr_i;
    end else if (grant && jmp_pend_q) begin
      // Stale request finally went out, now switch to the target
      pc_q       <= jump_valid_i ? jump_target_i : jmp_tgt_q;
      jmp_pend_q <= 1'b0;
    end else if (jump_valid_i && stall) begin
      // Held request must finish with its old address first
      jmp_pend_q <= 1'b1;
    end else if (jump_valid_i) begin
      pc_q <= jump_target_i;
    end else if (grant) begin
      pc_q <= pc_q + `FD_XLEN'(4);
    end
  end

  // Parked target while a stale request is still held on the bus
  always_ff @(posedge clk_i) begin
    if (jump_valid_i) begin
      jmp_tgt_q <= jump_target_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////

  assign out_cnt_d = out_cnt_q + `FD_CNT_W'(grant) - `FD_CNT_W'(instr_rvalid_i);
  assign drop_rsp  = instr_rvalid_i && (drop_cnt_q != '0);

  // Anything arriving in the jump cycle is pre-jump data
  assign push_o = instr_rvalid_i && (drop_cnt_q == '0) && !jump_valid_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_cnt_q  <= '0;
      drop_cnt_q <= '0;
    end else begin
      out_cnt_q <= out_cnt_d;
      if (jump_valid_i) begin
        // Every request still owed after this cycle is stale
        drop_cnt_q <= out_cnt_d;
      end else begin
        drop_cnt_q <= drop_cnt_q + `FD_CNT_W'(grant & jmp_pend_q) - `FD_CNT_W'(drop_rsp);
      end
    end
  end

  // Address queue pointers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aq_wr_ptr_q <= '0;
      aq_rd_ptr_q <= '0;
    end else begin
      if (grant) begin
        aq_wr_ptr_q <= aq_wr_ptr_q + 1'b1;
      end
      if (instr_rvalid_i) begin
        aq_rd_ptr_q <= aq_rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      aq_mem[aq_wr_ptr_q] <= pc_q;
    end
  end

  // Tag each response with the address of its own request
  assign push_entry_o.pc      = aq_mem[aq_rd_ptr_q];
  assign push_entry_o.instr   = instr_rdata_i;
  assign push_entry_o.bus_err = instr_err_i;

endmodule

// File: src/prefetch_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Circular buffer of fetched words, one cycle from push to pop
// Writer must respect count_o since a push into a full FIFO is lost
////////////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

module prefetch_fifo (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    flush_i,
  input  logic                    push_i,
  input  fetch_pkg::fetch_entry_t push_entry_i,
  input  logic                    pop_i,
  output logic                    head_valid_o,
  output fetch_pkg::fetch_entry_t head_o,
  output logic [`FD_CNT_W-1:0]    count_o
);

  fetch_pkg::fetch_entry_t mem [`FD_FIFO_DEPTH];
  logic [`FD_PTR_W-1:0]    wr_ptr_q;
  logic [`FD_PTR_W-1:0]    rd_ptr_q;
  logic [`FD_CNT_W-1:0]    count_q;
  logic                    do_push;
  logic                    do_pop;

  // Head disappears already in the flush cycle
  assign head_valid_o = (count_q != '0) && !flush_i;
  assign head_o       = mem[rd_ptr_q];
  assign count_o      = count_q;

  assign do_push = push_i && (count_q < `FD_FIFO_DEPTH);
  assign do_pop  = pop_i && head_valid_o;

  // Pointers and occupancy
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + `FD_CNT_W'(do_push) - `FD_CNT_W'(do_pop);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) begin
      mem[wr_ptr_q] <= push_entry_i;
    end
  end

endmodule

// File: src/instr_decoder.sv
////////////////////////////////////////////////////////////////////////////
// RV32 base decoder with a registered valid/ready output
// Fields a format does not have are reported as zero
// Illegal words report FMT_ILL with zero registers and immediate
////////////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

module instr_decoder (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    flush_i,
  input  logic                    head_valid_i,
  input  fetch_pkg::fetch_entry_t head_i,
  output logic                    pop_o,
  output logic                    dec_valid_o,
  output fetch_pkg::decoded_t     dec_o,
  input  logic                    dec_ready_i
);

  fetch_pkg::instr_u   instr;
  fetch_pkg::decoded_t dec_d;
  fetch_pkg::decoded_t dec_q;
  logic                dec_valid_q;
  logic                load;
  // Bits [31:12] of the word, the U and J payload
  logic [19:0]         upper;

  assign instr = head_i.instr;
  assign upper = {instr.i_view.imm12, instr.i_view.rs1, instr.i_view.funct3};

  ////////////////////////////////////////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    dec_d         = '0;
    dec_d.pc      = head_i.pc;
    dec_d.instr   = head_i.instr;
    dec_d.rd      = instr.r_view.rd;
    dec_d.rs1     = instr.r_view.rs1;
    dec_d.rs2     = instr.r_view.rs2;
    dec_d.illegal = 1'b0;
    case (instr.r_view.opcode)
      fetch_pkg::OP: begin
        dec_d.fmt = fetch_pkg::FMT_R;
      end
      fetch_pkg::OP_IMM, fetch_pkg::LOAD, fetch_pkg::JALR, fetch_pkg::SYSTEM: begin
        dec_d.fmt = fetch_pkg::FMT_I;
        dec_d.rs2 = '0;
        dec_d.imm = {{20{instr.i_view.imm12[11]}}, instr.i_view.imm12};
      end
      fetch_pkg::STORE: begin
        // Immediate split over funct7 and rd
        dec_d.fmt = fetch_pkg::FMT_S;
        dec_d.rd  = '0;
        dec_d.imm = {{20{instr.r_view.funct7[6]}}, instr.r_view.funct7, instr.r_view.rd};
      end
      fetch_pkg::BRANCH: begin
        dec_d.fmt = fetch_pkg::FMT_B;
        dec_d.rd  = '0;
        dec_d.imm = {{19{instr.r_view.funct7[6]}}, instr.r_view.funct7[6],
                     instr.r_view.rd[0], instr.r_view.funct7[5:0],
                     instr.r_view.rd[4:1], 1'b0};
      end
      fetch_pkg::LUI, fetch_pkg::AUIPC: begin
        dec_d.fmt = fetch_pkg::FMT_U;
        dec_d.rs1 = '0;
        dec_d.rs2 = '0;
        dec_d.imm = {upper, 12'b0};
      end
      fetch_pkg::JAL: begin
        // Scrambled J layout, bit 0 always zero
        dec_d.fmt = fetch_pkg::FMT_J;
        dec_d.rs1 = '0;
        dec_d.rs2 = '0;
        dec_d.imm = {{11{upper[19]}}, upper[19], upper[7:0], upper[8], upper[18:9], 1'b0};
      end
      default: begin
        dec_d.illegal = 1'b1;
      end
    endcase
    // Compressed encodings and fetch errors are illegal too
    if (instr.r_view.opcode[1:0] != 2'b11 || head_i.bus_err) begin
      dec_d.illegal = 1'b1;
    end
    if (dec_d.illegal) begin
      dec_d.fmt = fetch_pkg::FMT_ILL;
      dec_d.rd  = '0;
      dec_d.rs1 = '0;
      dec_d.rs2 = '0;
      dec_d.imm = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  // Take a new word when the register is empty or draining
  assign load  = head_valid_i && (!dec_valid_q || dec_ready_i);
  assign pop_o = load;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_valid_q <= 1'b0;
    end else if (flush_i) begin
      dec_valid_q <= 1'b0;
    end else if (load) begin
      dec_valid_q <= 1'b1;
    end else if (dec_ready_i) begin
      dec_valid_q <= 1'b0;
    end
  end

  // Packet only changes on load, so it holds under a stall
  always_ff @(posedge clk_i) begin
    if (load) begin
      dec_q <= dec_d;
    end
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_o       = dec_q;

endmodule

// File: src/fetch_decode_top.sv
////////////////////////////////////////////////////////////////////////////
// Instruction front end of a small RV32 core
// Prefetcher, prefetch FIFO and decoder, with a jump that flushes all three
////////////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

module fetch_decode_top (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic [`FD_XLEN-1:0] boot_addr_i,
  // Redirect
  input  logic                jump_valid_i,
  input  logic [`FD_XLEN-1:0] jump_target_i,
  // Instruction bus
  output logic                instr_req_o,
  output logic [`FD_XLEN-1:0] instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [`FD_XLEN-1:0] instr_rdata_i,
  input  logic                instr_err_i,
  // Decoded output
  output logic                dec_valid_o,
  output fetch_pkg::decoded_t dec_o,
  input  logic                dec_ready_i
);

  // Prefetcher to FIFO
  logic                    push;
  fetch_pkg::fetch_entry_t push_entry;
  logic [`FD_CNT_W-1:0]    fifo_count;

  // FIFO to decoder
  logic                    head_valid;
  fetch_pkg::fetch_entry_t head;
  logic                    pop;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////////////////////////////////////////

  prefetcher prefetcher_inst (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .boot_addr_i    ( boot_addr_i    ),
    .jump_valid_i   ( jump_valid_i   ),
    .jump_target_i  ( jump_target_i  ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_err_i    ( instr_err_i    ),
    .fifo_count_i   ( fifo_count     ),
    .push_o         ( push           ),
    .push_entry_o   ( push_entry     )
  );

  // Jump empties the FIFO in its own cycle
  prefetch_fifo prefetch_fifo_inst (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .flush_i      ( jump_valid_i ),
    .push_i       ( push         ),
    .push_entry_i ( push_entry   ),
    .pop_i        ( pop          ),
    .head_valid_o ( head_valid   ),
    .head_o       ( head         ),
    .count_o      ( fifo_count   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  instr_decoder instr_decoder_inst (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .flush_i      ( jump_valid_i ),
    .head_valid_i ( head_valid   ),
    .head_i       ( head         ),
    .pop_o        ( pop          ),
    .dec_valid_o  ( dec_valid_o  ),
    .dec_o        ( dec_o        ),
    .dec_ready_i  ( dec_ready_i  )
  );

endmodule

// File: tb/fetch_decode_assert.sv
////////////////////////////////////////////////////////////////////////////
// Bus, FIFO and output handshake checks bound into the front end top
// Reset must be released away from a rising clock edge
////////////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

module fetch_decode_assert (
  input logic                clk_i,
  input logic                arst_n_i,
  input logic                jump_valid_i,
  input logic                instr_req_o,
  input logic [`FD_XLEN-1:0] instr_addr_o,
  input logic                instr_gnt_i,
  input logic                push_i,
  input logic [`FD_CNT_W-1:0] fifo_count_i,
  input logic                dec_valid_o,
  input fetch_pkg::decoded_t dec_o,
  input logic                dec_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;

  // Stalled request keeps req and addr, also across a jump
  req_held_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o)
  ) else begin
    $error("instruction request dropped or changed before its grant");
    fail_cnt++;
  end

  // Credit gating leaves room for every pushed response
  // A push into a full FIFO would take it past its depth
  fifo_bound_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> fifo_count_i < `FD_FIFO_DEPTH
  ) else begin
    $error("prefetch FIFO pushed while already at its depth");
    fail_cnt++;
  end

  // Held packet under a stall, unless a jump flushes it
  dec_held_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    dec_valid_o && !dec_ready_i && !jump_valid_i |=> dec_valid_o && $stable(dec_o)
  ) else begin
    $error("decoded packet changed or vanished while stalled");
    fail_cnt++;
  end

  // Quiet bus and output in reset and on the first edge after it
  reset_quiet_a: assert property (
    @(posedge clk_i)
    (!arst_n_i || $rose(arst_n_i)) |-> !instr_req_o && !dec_valid_o
  ) else begin
    $error("request or decoded valid active right after reset");
    fail_cnt++;
  end

endmodule

bind fetch_decode_top fetch_decode_assert fetch_decode_assert_inst (
  .clk_i        ( clk_i        ),
  .arst_n_i     ( arst_n_i     ),
  .jump_valid_i ( jump_valid_i ),
  .instr_req_o  ( instr_req_o  ),
  .instr_addr_o ( instr_addr_o ),
  .instr_gnt_i  ( instr_gnt_i  ),
  .push_i       ( push         ),
  .fifo_count_i ( fifo_count   ),
  .dec_valid_o  ( dec_valid_o  ),
  .dec_o        ( dec_o        ),
  .dec_ready_i  ( dec_ready_i  )
);

// File: tb/tb_fetch_decode.sv
////////////////////////////////////////////////////////////////////////////
// Memory model grants at random and answers in order after 1 to 3 cycles
// Words repeat every 64 bytes and the 0x1000 page answers with a bus error
////////////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

module tb_fetch_decode;
  timeunit 1ns;
  timeprecision 1ps;

  logic                clk_i;
  logic                arst_n_i;
  logic [`FD_XLEN-1:0] boot_addr_i;
  logic                jump_valid_i;
  logic [`FD_XLEN-1:0] jump_target_i;
  logic                instr_req_o;
  logic [`FD_XLEN-1:0] instr_addr_o;
  logic                instr_gnt_i;
  logic                instr_rvalid_i;
  logic [`FD_XLEN-1:0] instr_rdata_i;
  logic                instr_err_i;
  logic                dec_valid_o;
  fetch_pkg::decoded_t dec_o;
  logic                dec_ready_i;

  // Memory model state
  logic [31:0] rand_state;
  int          cycle;
  int          last_due;
  logic [31:0] rsp_addr_q [$];
  int          rsp_due_q  [$];

  // Scoreboard
  logic [31:0] exp_pc;
  string       cur_test;
  int          test_errors;
  int          n_tests;
  int          n_errors;

  fetch_decode_top fetch_decode_top_inst (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .boot_addr_i    ( boot_addr_i    ),
    .jump_valid_i   ( jump_valid_i   ),
    .jump_target_i  ( jump_target_i  ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_err_i    ( instr_err_i    ),
    .dec_valid_o    ( dec_valid_o    ),
    .dec_o          ( dec_o          ),
    .dec_ready_i    ( dec_ready_i    )
  );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference data
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Instruction table, indexed by word within a 64 byte block
  function automatic logic [31:0] table_word(input logic [31:0] addr);
    logic [31:0] w;
    case (addr[5:2])
      4'd0:    w = 32'h002081b3;  // add   x3, x1, x2
      4'd1:    w = 32'hfff00293;  // addi  x5, x0, -1
      4'd2:    w = 32'h00812303;  // lw    x6, 8(x2)
      4'd3:    w = 32'hfe712e23;  // sw    x7, -4(x2)
      4'd4:    w = 32'hfe208ce3;  // beq   x1, x2, -8
      4'd5:    w = 32'h001000ef;  // jal   x1, 2048
      4'd6:    w = 32'h00008067;  // jalr  x0, 0(x1)
      4'd7:    w = 32'h12345537;  // lui   x10, 0x12345
      4'd8:    w = 32'hfffff597;  // auipc x11, 0xfffff
      4'd9:    w = 32'h00000073;  // ecall
      4'd10:   w = 32'h00000001;  // c.nop, compressed
      4'd11:   w = 32'h0000000b;  // custom-0, not decoded
      4'd12:   w = 32'h40628233;  // sub   x4, x5, x6
      4'd13:   w = 32'h07f3f393;  // andi  x7, x7, 0x7f
      4'd14:   w = 32'h00019863;  // bne   x3, x0, 16
      default: w = 32'h001000a3;  // sb    x1, 1(x0)
    endcase
    return w;
  endfunction

  function automatic logic page_error(input logic [31:0] addr);
    return addr[31:12] == 20'h00001;
  endfunction

  // RV32 field rules, straight from the word bits
  function automatic fetch_pkg::decoded_t expected_packet(input logic [31:0] pc,
                                                          input logic [31:0] w,
                                                          input logic        err);
    fetch_pkg::decoded_t p;
    p       = '0;
    p.pc    = pc;
    p.instr = w;
    p.fmt   = fetch_pkg::FMT_ILL;
    if (!err && w[1:0] == 2'b11) begin
      case (w[6:0])
        7'h33: begin
          p.fmt = fetch_pkg::FMT_R;
          p.rd  = w[11:7];
          p.rs1 = w[19:15];
          p.rs2 = w[24:20];
        end
        7'h13, 7'h03, 7'h67, 7'h73: begin
          p.fmt = fetch_pkg::FMT_I;
          p.rd  = w[11:7];
          p.rs1 = w[19:15];
          p.imm = {{20{w[31]}}, w[31:20]};
        end
        7'h23: begin
          p.fmt = fetch_pkg::FMT_S;
          p.rs1 = w[19:15];
          p.rs2 = w[24:20];
          p.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        end
        7'h63: begin
          p.fmt = fetch_pkg::FMT_B;
          p.rs1 = w[19:15];
          p.rs2 = w[24:20];
          p.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        7'h37, 7'h17: begin
          p.fmt = fetch_pkg::FMT_U;
          p.rd  = w[11:7];
          p.imm = {w[31:12], 12'h000};
        end
        7'h6f: begin
          p.fmt = fetch_pkg::FMT_J;
          p.rd  = w[11:7];
          p.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        default: begin
          p.fmt = fetch_pkg::FMT_ILL;
        end
      endcase
    end
    p.illegal = (p.fmt == fetch_pkg::FMT_ILL);
    return p;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////

  // req and addr come from flops, so they are settled at the falling edge
  always @(negedge clk_i) begin
    int          delay;
    int          due;
    logic [31:0] addr;
    if (arst_n_i) begin
      cycle = cycle + 1;
      // Oldest response goes out once its delay has passed
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
        addr = rsp_addr_q.pop_front();
        void'(rsp_due_q.pop_front());
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = table_word(addr);
        instr_err_i    = page_error(addr);
      end else begin
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = '0;
        instr_err_i    = 1'b0;
      end
      rand_state  = next_random(rand_state);
      instr_gnt_i = (rand_state[31:30] != 2'b00);
      // Transfer completes on the coming rising edge
      if (instr_req_o && instr_gnt_i) begin
        delay = 1 + int'(rand_state[23:22]) % 3;
        due   = cycle + delay;
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_addr_q.push_back(instr_addr_o);
        rsp_due_q.push_back(due);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %-14s %s", cur_test, (test_errors == 0) ? "ok" : "FAILED");
    n_tests  = n_tests + 1;
    n_errors = n_errors + test_errors;
  endtask

  // Accept and check packets, the transfer lands on the next rising edge
  task automatic collect_packets(input int count, input int limit);
    fetch_pkg::decoded_t exp;
    int                  got;
    int                  waited;
    got    = 0;
    waited = 0;
    while (got < count && waited < limit) begin
      @(negedge clk_i);
      dec_ready_i = 1'b1;
      waited++;
      if (dec_valid_o) begin
        exp = expected_packet(exp_pc, table_word(exp_pc), page_error(exp_pc));
        if (dec_o !== exp) begin
          $display("** Error %s: expected %h, actual %h", cur_test, exp, dec_o);
          test_errors++;
        end
        exp_pc = exp_pc + 32'd4;
        got++;
      end
    end
    if (got < count) begin
      $display("%s: only %0d of %0d packets arrived within %0d cycles",
               cur_test, got, count, limit);
      test_errors++;
    end
  endtask

  // One cycle redirect, the packet held in that cycle is flushed
  task automatic jump_to(input logic [31:0] target);
    @(negedge clk_i);
    dec_ready_i   = 1'b0;
    jump_valid_i  = 1'b1;
    jump_target_i = target;
    @(negedge clk_i);
    jump_valid_i = 1'b0;
    exp_pc       = target;
  endtask

  task automatic hold_ready_low(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      dec_ready_i = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    boot_addr_i    = 32'h0000_0080;
    jump_valid_i   = 1'b0;
    jump_target_i  = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    dec_ready_i    = 1'b0;
    rand_state     = 32'hc966_9b73;
    cycle          = 0;
    last_due       = 0;
    n_tests        = 0;
    n_errors       = 0;
    exp_pc         = 32'h0000_0080;

    repeat (8) @(negedge clk_i);
    arst_n_i = 1'b1;

    // Two passes over the table, compressed and unknown words included
    begin_test("seq_fetch");
    collect_packets(36, 400);
    end_test();

    begin_test("bus_error");
    jump_to(32'h0000_1000);
    collect_packets(6, 200);
    end_test();

    // Short runs between jumps leave requests in flight
    begin_test("jump");
    for (int i = 0; i < 4; i++) begin
      jump_to(32'h0000_0300 + 32'h44 * i);
      collect_packets(3, 200);
    end
    end_test();

    begin_test("backpressure");
    hold_ready_low(20);
    collect_packets(16, 200);
    end_test();

    n_errors = n_errors + fetch_decode_top_inst.fetch_decode_assert_inst.fail_cnt;
    $display("%0d tests run, %0d errors", n_tests, n_errors);
    if (n_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+src
src/fetch_pkg.sv
src/prefetcher.sv
src/prefetch_fifo.sv
src/instr_decoder.sv
src/fetch_decode_top.sv
tb/fetch_decode_assert.sv
tb/tb_fetch_decode.sv

// File: Bender.yml
package:
  name: fetch_decode

sources:
  - include_dirs:
      - src
    files:
      - src/fetch_pkg.sv
      - src/prefetcher.sv
      - src/prefetch_fifo.sv
      - src/instr_decoder.sv
      - src/fetch_decode_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/fetch_decode_assert.sv
      - tb/tb_fetch_decode.sv
